//--- bench/cp0_tlb_checker.sv
`timescale 1ns/1ps

module cp0_tlb_checker (
    input logic clk,
    input logic reset,
    input logic ws_valid,
    input logic ws_ex,
    input logic eret_flush,
    input logic int_req,
    input logic status_exl,
    input logic mtc0_we
);

    // An exception in the same cycle kills eret
    assert property (@(posedge clk) disable iff (reset) ws_ex |-> !eret_flush)
        else $error("eret_flush high together with ws_ex");

    assert property (@(posedge clk) disable iff (reset) status_exl |-> !int_req)
        else $error("int_req high while EXL is set");

    // EXL only rises through exception entry or an mtc0
    assert property (@(posedge clk) disable iff (reset)
        (!status_exl && !(ws_valid && ws_ex) && !mtc0_we) |=> !status_exl)
        else $error("EXL rose without exception or mtc0");

endmodule

bind cp0_regs cp0_tlb_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .ws_valid   (ws_valid),
    .ws_ex      (ws_ex),
    .eret_flush (eret_flush),
    .int_req    (int_req),
    .status_exl (status_exl),
    .mtc0_we    (mtc0_we)
);

//--- bench/cp0_tlb_tb.sv
`timescale 1ns/1ps

module cp0_tlb_tb;
    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int NENT = TLBNUM_DEFAULT;
    localparam int TEST_CYCLES = 150 + 100 + 300 + 400 + 50 + 200; // Per-test budgets
    localparam int TIMEOUT_NS = TEST_CYCLES * 40 + 2000;

    logic clk;
    logic reset;
    logic ws_valid;
    cp0_op_e ws_op;
    logic [7:0] ws_reg_addr;
    logic [31:0] ws_wdata;
    logic ws_ex;
    exc_code_e ws_exc_code;
    logic ws_bd;
    logic [31:0] ws_pc;
    logic [31:0] ws_badvaddr;
    logic [5:0] ext_int;
    logic [VPN2_W-1:0] s_vpn2;
    logic s_odd_page;
    logic [ASID_W-1:0] s_asid;
    logic [31:0] rdata;
    logic eret_flush;
    logic [31:0] epc;
    logic int_req;
    logic s_found;
    logic [PFN_W-1:0] s_pfn;
    logic [CATTR_W-1:0] s_c;
    logic s_d;
    logic s_v;
    logic [ASID_W-1:0] cur_asid;

    // Mirror of the CP0 registers
    logic [7:0] m_im;
    logic m_exl, m_ie, m_bd, m_ti, m_index_p;
    logic [7:0] m_ip;
    logic [4:0] m_exc;
    logic [31:0] m_epc, m_badvaddr;
    logic m_bva_set; // BadVAddr has no reset value
    logic [VPN2_W-1:0] m_vpn2;
    logic [ASID_W-1:0] m_asid;
    logic [25:0] m_lo0, m_lo1;
    logic [3:0] m_index;
    // Mirror TLB, page halves kept as {PFN, C, D, V}
    logic t_used [NENT];
    logic [VPN2_W-1:0] t_vpn2 [NENT];
    logic [ASID_W-1:0] t_asid [NENT];
    logic t_g [NENT];
    logic [24:0] t_lo0 [NENT];
    logic [24:0] t_lo1 [NENT];

    string cur_test, chk_name;
    logic [31:0] chk_exp, chk_act, last_rdata;
    logic last_flush;
    event chk_ev;
    int test_errors, total_errors, n_checks, n_tests, cyc;
    exc_code_e codes [10];

    cp0_tlb_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    // Comparing process
    always @(chk_ev) begin
        n_checks++;
        assert (chk_act === chk_exp) else begin
            $display("[FAIL] %s %s expected %h actual %h", cur_test, chk_name, chk_exp, chk_act);
            test_errors++;
        end
    end

    function automatic logic [31:0] cp0_expected(input logic [7:0] addr);
        case (addr)
            INDEX_ADDR:    return {m_index_p, 27'b0, m_index};
            ENTRYLO0_ADDR: return {6'b0, m_lo0};
            ENTRYLO1_ADDR: return {6'b0, m_lo1};
            BADVADDR_ADDR: return m_badvaddr;
            ENTRYHI_ADDR:  return {m_vpn2, 5'b0, m_asid};
            STATUS_ADDR:   return {9'b0, 1'b1, 6'b0, m_im, 6'b0, m_exl, m_ie}; // BEV fixed
            CAUSE_ADDR:    return {m_bd, m_ti, 14'b0, m_ip, 1'b0, m_exc, 2'b0};
            EPC_ADDR:      return m_epc;
            default:       return 32'h0;
        endcase
    endfunction

    function automatic logic ref_match(input int i, input logic [VPN2_W-1:0] vpn2,
                                       input logic [ASID_W-1:0] asid);
        return t_used[i] && t_vpn2[i] == vpn2 && (t_g[i] || t_asid[i] == asid);
    endfunction

    function automatic logic [31:0] ref_search(input logic [VPN2_W-1:0] vpn2,
                                               input logic odd, input logic [ASID_W-1:0] asid);
        for (int i = 0; i < NENT; i++) begin
            if (ref_match(i, vpn2, asid)) begin
                return {6'b0, 1'b1, odd ? t_lo1[i] : t_lo0[i]};
            end
        end
        return 32'h0;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_name = name;
        chk_exp = exp;
        chk_act = act;
        -> chk_ev;
        #0;
    endtask

    task automatic cp0_op(input cp0_op_e op, input logic [7:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        ws_valid <= 1'b1;
        ws_op <= op;
        ws_reg_addr <= addr;
        ws_wdata <= wdata;
        @(negedge clk);
        last_rdata = rdata;
        last_flush = eret_flush;
        @(posedge clk); // Op taken at this edge
        ws_valid <= 1'b0;
        ws_op <= OP_NONE;
        ws_ex <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, input string name);
        cp0_op(OP_MFC0, addr, 32'h0);
        check(name, cp0_expected(addr), last_rdata);
    endtask

    task automatic mtc0(input logic [7:0] addr, input logic [31:0] w);
        cp0_op(OP_MTC0, addr, w);
        case (addr)
            STATUS_ADDR: begin
                m_im = w[15:8];
                m_exl = w[1];
                m_ie = w[0];
            end
            CAUSE_ADDR:    m_ip[1:0] = w[9:8];
            EPC_ADDR:      m_epc = w;
            ENTRYHI_ADDR: begin
                m_vpn2 = w[31:13];
                m_asid = w[7:0];
            end
            ENTRYLO0_ADDR: m_lo0 = w[25:0];
            ENTRYLO1_ADDR: m_lo1 = w[25:0];
            INDEX_ADDR:    m_index = w[3:0];
            default: ;
        endcase
    endtask

    task automatic take_exc(input exc_code_e code, input logic bd, input logic [31:0] pc,
                            input logic [31:0] bva);
        @(posedge clk);
        ws_ex <= 1'b1;
        ws_exc_code <= code;
        ws_bd <= bd;
        ws_pc <= pc;
        ws_badvaddr <= bva;
        cp0_op(OP_NONE, 8'h0, 32'h0); // cp0_op raises ws_valid in the next cycle
        if (!m_exl) begin
            m_epc = bd ? pc - 32'd4 : pc;
            m_bd = bd;
        end
        m_exl = 1'b1;
        m_exc = code;
        if (code inside {EXC_ADEL, EXC_ADES, EXC_TLBL, EXC_TLBS, EXC_MOD}) begin
            m_badvaddr = bva;
            m_bva_set = 1'b1;
        end
        if (code inside {EXC_TLBL, EXC_TLBS, EXC_MOD}) m_vpn2 = bva[31:13];
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", cur_test, test_errors);
        total_errors += test_errors;
        n_tests++;
    endtask

    initial begin
        logic [31:0] w, c;
        int t0, k, bound, mode;
        logic seen;
        logic [ASID_W-1:0] a;
        void'($urandom(35966));
        codes = '{EXC_INT, EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL,
                  EXC_ADES, EXC_SYS, EXC_BP, EXC_RI, EXC_OV};
        reset = 1'b1;
        ws_valid = 1'b0;
        ws_op = OP_NONE;
        ws_reg_addr = 8'h0;
        ws_wdata = 32'h0;
        ws_ex = 1'b0;
        ws_exc_code = EXC_INT;
        ws_bd = 1'b0;
        ws_pc = 32'h0;
        ws_badvaddr = 32'h0;
        ext_int = 6'h0;
        s_vpn2 = '0;
        s_odd_page = 1'b0;
        s_asid = '0;
        {m_im, m_exl, m_ie, m_bd, m_ti, m_index_p, m_ip, m_exc} = '0;
        {m_epc, m_badvaddr, m_vpn2, m_asid, m_lo0, m_lo1, m_index} = '0;
        m_bva_set = 1'b0;
        for (int i = 0; i < NENT; i++) t_used[i] = 1'b0;
        total_errors = 0;
        n_checks = 0;
        n_tests = 0;
        cyc = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        begin_test("mtc0_readback");
        for (int r = 0; r < 3; r++) begin
            mtc0(STATUS_ADDR, $urandom());
            mtc0(CAUSE_ADDR, $urandom());
            mtc0(EPC_ADDR, $urandom());
            mtc0(ENTRYHI_ADDR, $urandom());
            mtc0(ENTRYLO0_ADDR, $urandom());
            mtc0(ENTRYLO1_ADDR, $urandom());
            mtc0(INDEX_ADDR, $urandom());
            read_reg(STATUS_ADDR, "status");
            read_reg(CAUSE_ADDR, "cause");
            read_reg(EPC_ADDR, "epc");
            read_reg(ENTRYHI_ADDR, "entryhi");
            read_reg(ENTRYLO0_ADDR, "entrylo0");
            read_reg(ENTRYLO1_ADDR, "entrylo1");
            read_reg(INDEX_ADDR, "index");
        end
        mtc0(STATUS_ADDR, 32'h0);
        end_test();

        begin_test("exception");
        for (int r = 0; r < 4; r++) begin
            take_exc(codes[$urandom() % 10], $urandom() % 2, $urandom() & ~32'h3, $urandom());
            read_reg(EPC_ADDR, "epc");
            check("epc_out", m_epc, epc);
            read_reg(CAUSE_ADDR, "cause");
            if (m_bva_set) read_reg(BADVADDR_ADDR, "badvaddr");
            read_reg(ENTRYHI_ADDR, "entryhi");
            take_exc(codes[$urandom() % 10], $urandom() % 2, $urandom() & ~32'h3, $urandom());
            read_reg(EPC_ADDR, "epc_nested");
            read_reg(CAUSE_ADDR, "cause_nested");
            cp0_op(OP_ERET, 8'h0, 32'h0);
            m_exl = 1'b0;
            check("eret_flush", 32'h1, {31'b0, last_flush});
            read_reg(STATUS_ADDR, "status_after_eret");
        end
        end_test();

        begin_test("timer");
        w = $urandom() & 32'h0fff_ffff;
        mtc0(COUNT_ADDR, w);
        t0 = cyc;
        repeat (5 + $urandom() % 16) @(posedge clk);
        cp0_op(OP_MFC0, COUNT_ADDR, 32'h0);
        c = last_rdata;
        k = cyc - t0;
        assert (c >= w && c <= w + k / 2 + 1) else begin
            $display("[FAIL] %s count expected %h..%h actual %h", cur_test, w, w + k / 2 + 1, c);
            test_errors++;
        end
        mtc0(COMPARE_ADDR, c + 32'd5);
        bound = 2 * 5 + 8;
        seen = 1'b0;
        t0 = cyc;
        while (!seen && cyc - t0 < bound) begin
            cp0_op(OP_MFC0, CAUSE_ADDR, 32'h0);
            seen = last_rdata[30];
        end
        assert (seen) else begin
            $display("Timer interrupt did not set within %0d cycles", bound);
            test_errors++;
        end
        @(posedge clk);
        m_ti = 1'b1;
        m_ip[7] = 1'b1; // IP7 follows TI one cycle later
        read_reg(CAUSE_ADDR, "cause_ti_set");
        mtc0(COMPARE_ADDR, 32'hffff_ffff);
        m_ti = 1'b0;
        m_ip[7] = 1'b0;
        read_reg(CAUSE_ADDR, "cause_ti_clear");
        end_test();

        begin_test("tlb_write_read");
        for (int r = 0; r < 10; r++) begin
            k = $urandom() % NENT;
            mtc0(ENTRYHI_ADDR, $urandom());
            mtc0(ENTRYLO0_ADDR, $urandom());
            mtc0(ENTRYLO1_ADDR, $urandom());
            mtc0(INDEX_ADDR, k);
            cp0_op(OP_TLBWI, 8'h0, 32'h0);
            t_used[k] = 1'b1;
            t_vpn2[k] = m_vpn2;
            t_asid[k] = m_asid;
            t_g[k] = m_lo0[0] & m_lo1[0];
            t_lo0[k] = m_lo0[25:1];
            t_lo1[k] = m_lo1[25:1];
            mtc0(ENTRYHI_ADDR, 32'h0);
            mtc0(ENTRYLO0_ADDR, 32'h0);
            cp0_op(OP_TLBR, 8'h0, 32'h0);
            m_vpn2 = t_vpn2[k];
            m_asid = t_asid[k];
            m_lo0 = {t_lo0[k], t_g[k]};
            m_lo1 = {t_lo1[k], t_g[k]};
            read_reg(ENTRYHI_ADDR, "entryhi");
            check("cur_asid", {24'b0, m_asid}, {24'b0, cur_asid});
            read_reg(ENTRYLO0_ADDR, "entrylo0");
            read_reg(ENTRYLO1_ADDR, "entrylo1");
            // Probe with a hit, then with a likely miss
            for (int p = 0; p < 2; p++) begin
                if (p == 1) mtc0(ENTRYHI_ADDR, $urandom());
                cp0_op(OP_TLBP, 8'h0, 32'h0);
                m_index_p = 1'b1;
                for (int i = NENT - 1; i >= 0; i--) begin
                    if (ref_match(i, m_vpn2, m_asid)) begin
                        m_index_p = 1'b0;
                        m_index = i;
                    end
                end
                read_reg(INDEX_ADDR, p == 0 ? "tlbp_hit" : "tlbp_miss");
            end
        end
        end_test();

        begin_test("translation");
        for (int r = 0; r < 16; r++) begin
            do begin
                k = $urandom() % NENT; // Only entries the mirror knows
            end while (!t_used[k]);
            mode = $urandom() % 3;
            a = mode == 1 ? t_asid[k] ^ 8'h5a : t_asid[k];
            @(posedge clk);
            s_vpn2 <= mode == 2 ? VPN2_W'($urandom()) : t_vpn2[k];
            s_asid <= a;
            s_odd_page <= $urandom() % 2;
            @(negedge clk);
            check("search", ref_search(s_vpn2, s_odd_page, s_asid),
                  {6'b0, s_found, s_pfn, s_c, s_d, s_v});
        end
        end_test();

        begin_test("interrupt");
        for (int r = 0; r < 12; r++) begin
            @(posedge clk);
            ext_int <= $urandom();
            mtc0(STATUS_ADDR, $urandom() & 32'h0000_ff01);
            m_ip[7:2] = {ext_int[5] | m_ti, ext_int[4:0]};
            @(negedge clk);
            check("int_req", {31'b0, m_ie && !m_exl && |(m_ip & m_im)}, {31'b0, int_req});
        end
        @(posedge clk);
        ext_int <= 6'h0;
        mtc0(STATUS_ADDR, 32'h0);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
logic/cp0_pkg.sv
logic/tlb_pkg.sv
logic/cp0_timer.sv
logic/cp0_regs.sv
logic/tlb.sv
logic/cp0_tlb_top.sv
bench/cp0_tlb_checker.sv
bench/cp0_tlb_tb.sv

//--- logic/cp0_pkg.sv
package cp0_pkg;

    // CP0 operation carried by the write-back stage
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MTC0  = 3'd1,
        OP_MFC0  = 3'd2,
        OP_ERET  = 3'd3,
        OP_TLBR  = 3'd4,
        OP_TLBWI = 3'd5,
        OP_TLBP  = 3'd6
    } cp0_op_e;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_MOD  = 5'h01, // Store to clean page
        EXC_TLBL = 5'h02,
        EXC_TLBS = 5'h03,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c
    } exc_code_e;

    // Register addresses as {rd, sel}
    localparam logic [7:0] INDEX_ADDR    = {5'd0, 3'd0};
    localparam logic [7:0] ENTRYLO0_ADDR = {5'd2, 3'd0};
    localparam logic [7:0] ENTRYLO1_ADDR = {5'd3, 3'd0};
    localparam logic [7:0] BADVADDR_ADDR = {5'd8, 3'd0};
    localparam logic [7:0] COUNT_ADDR    = {5'd9, 3'd0};
    localparam logic [7:0] ENTRYHI_ADDR  = {5'd10, 3'd0};
    localparam logic [7:0] COMPARE_ADDR  = {5'd11, 3'd0};
    localparam logic [7:0] STATUS_ADDR   = {5'd12, 3'd0};
    localparam logic [7:0] CAUSE_ADDR    = {5'd13, 3'd0};
    localparam logic [7:0] EPC_ADDR      = {5'd14, 3'd0};

    // Far away so no timer interrupt fires right after reset
    localparam logic [31:0] COMPARE_RESET = 32'hffff_ffff;

endpackage

//--- logic/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
    parameter int TLBNUM = tlb_pkg::TLBNUM_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ws_valid,
    input  cp0_pkg::cp0_op_e            ws_op,
    input  logic [7:0]                  ws_reg_addr,
    input  logic [31:0]                 ws_wdata,
    input  logic                        ws_ex,
    input  cp0_pkg::exc_code_e          ws_exc_code,
    input  logic                        ws_bd,
    input  logic [31:0]                 ws_pc,
    input  logic [31:0]                 ws_badvaddr,
    input  logic [5:0]                  ext_int,
    output logic [31:0]                 rdata,
    output logic                        eret_flush,
    output logic [31:0]                 epc,
    output logic                        int_req,
    output logic [tlb_pkg::ASID_W-1:0]  cur_asid,
    // Timer
    output logic                        count_we,
    output logic                        compare_we,
    output logic [31:0]                 timer_wdata,
    input  logic [31:0]                 count,
    input  logic [31:0]                 compare,
    input  logic                        timer_int,
    // TLB probe
    output logic [tlb_pkg::VPN2_W-1:0]  p_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]  p_asid,
    input  logic                        p_found,
    input  logic [$clog2(TLBNUM)-1:0]   p_index,
    // TLB write
    output logic                        w_we,
    output logic [$clog2(TLBNUM)-1:0]   w_index,
    output logic [tlb_pkg::VPN2_W-1:0]  w_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]  w_asid,
    output logic                        w_g,
    output logic [tlb_pkg::PFN_W-1:0]   w_pfn0,
    output logic [tlb_pkg::CATTR_W-1:0] w_c0,
    output logic                        w_d0,
    output logic                        w_v0,
    output logic [tlb_pkg::PFN_W-1:0]   w_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0] w_c1,
    output logic                        w_d1,
    output logic                        w_v1,
    // TLB read
    output logic [$clog2(TLBNUM)-1:0]   r_index,
    input  logic [tlb_pkg::VPN2_W-1:0]  r_vpn2,
    input  logic [tlb_pkg::ASID_W-1:0]  r_asid,
    input  logic                        r_g,
    input  logic [tlb_pkg::PFN_W-1:0]   r_pfn0,
    input  logic [tlb_pkg::CATTR_W-1:0] r_c0,
    input  logic                        r_d0,
    input  logic                        r_v0,
    input  logic [tlb_pkg::PFN_W-1:0]   r_pfn1,
    input  logic [tlb_pkg::CATTR_W-1:0] r_c1,
    input  logic                        r_d1,
    input  logic                        r_v1
);
    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLBNUM);
    localparam int LO_W = PFN_W + CATTR_W + 3; // {PFN, C, D, V, G}

    logic [7:0]        status_im;
    logic              status_exl;
    logic              status_ie;
    logic              cause_bd;
    logic [7:0]        cause_ip;
    exc_code_e         cause_exc;
    logic [31:0]       epc_q;
    logic [31:0]       badvaddr;
    logic [VPN2_W-1:0] hi_vpn2;
    logic [ASID_W-1:0] hi_asid;
    logic [LO_W-1:0]   entrylo0;
    logic [LO_W-1:0]   entrylo1;
    logic              index_p;
    logic [IDX_W-1:0]  index_idx;
    logic              op_ok;
    logic              mtc0_we;
    logic              ex_take;
    logic              tlb_exc;
    logic              tlbr_do;

    assign op_ok    = ws_valid && !ws_ex; // An exception kills the op
    assign ex_take  = ws_valid && ws_ex;
    assign mtc0_we  = op_ok && ws_op == OP_MTC0;
    assign tlbr_do  = op_ok && ws_op == OP_TLBR;
    assign tlb_exc  = ws_exc_code inside {EXC_TLBL, EXC_TLBS, EXC_MOD};

    assign eret_flush = op_ok && ws_op == OP_ERET;
    assign epc        = epc_q;
    assign int_req    = status_ie && !status_exl && |(cause_ip & status_im);
    assign cur_asid   = hi_asid;

    assign count_we    = mtc0_we && ws_reg_addr == COUNT_ADDR;
    assign compare_we  = mtc0_we && ws_reg_addr == COMPARE_ADDR;
    assign timer_wdata = ws_wdata;

    // Probe, write and read ports all work off EntryHi/EntryLo/Index
    assign p_vpn2  = hi_vpn2;
    assign p_asid  = hi_asid;
    assign w_we    = op_ok && ws_op == OP_TLBWI;
    assign w_index = index_idx;
    assign w_vpn2  = hi_vpn2;
    assign w_asid  = hi_asid;
    assign w_g     = entrylo0[0] & entrylo1[0]; // Global only if both halves say so
    assign {w_pfn0, w_c0, w_d0, w_v0} = entrylo0[LO_W-1:1];
    assign {w_pfn1, w_c1, w_d1, w_v1} = entrylo1[LO_W-1:1];
    assign r_index = index_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= '0;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (ex_take) begin
            status_exl <= 1'b1;
        end else if (eret_flush) begin
            status_exl <= 1'b0;
        end else if (mtc0_we && ws_reg_addr == STATUS_ADDR) begin
            status_im  <= ws_wdata[15:8];
            status_exl <= ws_wdata[1];
            status_ie  <= ws_wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd  <= 1'b0;
            cause_ip  <= '0;
            cause_exc <= EXC_INT;
        end else begin
            cause_ip[7]   <= ext_int[5] | timer_int; // Timer shares IP7
            cause_ip[6:2] <= ext_int[4:0];
            if (ex_take) begin
                if (!status_exl) begin
                    cause_bd <= ws_bd;
                end
                cause_exc <= ws_exc_code;
            end else if (mtc0_we && ws_reg_addr == CAUSE_ADDR) begin
                cause_ip[1:0] <= ws_wdata[9:8]; // Software interrupts
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_take && !status_exl) begin
            epc_q <= ws_bd ? ws_pc - 32'd4 : ws_pc; // Point at the branch
        end else if (mtc0_we && ws_reg_addr == EPC_ADDR) begin
            epc_q <= ws_wdata;
        end
        if (ex_take && (tlb_exc || ws_exc_code inside {EXC_ADEL, EXC_ADES})) begin
            badvaddr <= ws_badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_vpn2  <= '0;
            hi_asid  <= '0;
            entrylo0 <= '0;
            entrylo1 <= '0;
        end else if (ex_take) begin
            if (tlb_exc) begin
                hi_vpn2 <= ws_badvaddr[31 -: VPN2_W]; // Page pair for the refill handler
            end
        end else if (tlbr_do) begin
            hi_vpn2  <= r_vpn2;
            hi_asid  <= r_asid;
            entrylo0 <= {r_pfn0, r_c0, r_d0, r_v0, r_g};
            entrylo1 <= {r_pfn1, r_c1, r_d1, r_v1, r_g};
        end else if (mtc0_we) begin
            case (ws_reg_addr)
                ENTRYHI_ADDR: begin
                    hi_vpn2 <= ws_wdata[31 -: VPN2_W];
                    hi_asid <= ws_wdata[ASID_W-1:0];
                end
                ENTRYLO0_ADDR: entrylo0 <= ws_wdata[LO_W-1:0];
                ENTRYLO1_ADDR: entrylo1 <= ws_wdata[LO_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_idx <= '0;
        end else if (op_ok && ws_op == OP_TLBP) begin
            index_p <= !p_found; // P flags a miss
            if (p_found) begin
                index_idx <= p_index;
            end
        end else if (mtc0_we && ws_reg_addr == INDEX_ADDR) begin
            index_idx <= ws_wdata[IDX_W-1:0];
        end
    end

    // mfc0 read value
    always_comb begin
        case (ws_reg_addr)
            INDEX_ADDR:    rdata = {index_p, {(31-IDX_W){1'b0}}, index_idx};
            ENTRYLO0_ADDR: rdata = {{(32-LO_W){1'b0}}, entrylo0};
            ENTRYLO1_ADDR: rdata = {{(32-LO_W){1'b0}}, entrylo1};
            BADVADDR_ADDR: rdata = badvaddr;
            COUNT_ADDR:    rdata = count;
            ENTRYHI_ADDR:  rdata = {hi_vpn2, {(32-VPN2_W-ASID_W){1'b0}}, hi_asid};
            COMPARE_ADDR:  rdata = compare;
            STATUS_ADDR:   rdata = {9'b0, 1'b1, 6'b0, status_im, 6'b0, status_exl, status_ie};
            CAUSE_ADDR:    rdata = {cause_bd, timer_int, 14'b0, cause_ip, 1'b0, cause_exc, 2'b0};
            EPC_ADDR:      rdata = epc_q;
            default:       rdata = '0;
        endcase
    end

endmodule

//--- logic/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic        count_we,
    input  logic        compare_we,
    input  logic [31:0] timer_wdata,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);
    import cp0_pkg::*;

    logic tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            tick  <= 1'b0;
            count <= '0;
        end else begin
            tick <= ~tick; // Count runs at half the core clock
            if (count_we) begin
                count <= timer_wdata;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= COMPARE_RESET;
        end else if (compare_we) begin
            compare <= timer_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (compare_we) begin
            timer_int <= 1'b0; // Acknowledge by rewriting Compare
        end else if (count == compare) begin
            timer_int <= 1'b1; // Sticky until acknowledged
        end
    end

endmodule

//--- logic/cp0_tlb_top.sv
`timescale 1ns/1ps

module cp0_tlb_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ws_valid,
    input  cp0_pkg::cp0_op_e            ws_op,
    input  logic [7:0]                  ws_reg_addr,
    input  logic [31:0]                 ws_wdata,
    input  logic                        ws_ex,
    input  cp0_pkg::exc_code_e          ws_exc_code,
    input  logic                        ws_bd,
    input  logic [31:0]                 ws_pc,
    input  logic [31:0]                 ws_badvaddr,
    input  logic [5:0]                  ext_int,
    input  logic [tlb_pkg::VPN2_W-1:0]  s_vpn2,
    input  logic                        s_odd_page,
    input  logic [tlb_pkg::ASID_W-1:0]  s_asid,
    output logic [31:0]                 rdata,
    output logic                        eret_flush,
    output logic [31:0]                 epc,
    output logic                        int_req,
    output logic                        s_found,
    output logic [tlb_pkg::PFN_W-1:0]   s_pfn,
    output logic [tlb_pkg::CATTR_W-1:0] s_c,
    output logic                        s_d,
    output logic                        s_v,
    output logic [tlb_pkg::ASID_W-1:0]  cur_asid
);
    import tlb_pkg::*;

    localparam int TLBNUM = TLBNUM_DEFAULT;
    localparam int IDX_W = $clog2(TLBNUM);

    // CP0 to timer
    logic               count_we;
    logic               compare_we;
    logic [31:0]        timer_wdata;
    logic [31:0]        count;
    logic [31:0]        compare;
    logic               timer_int;
    // CP0 to TLB probe, write and read ports
    logic [VPN2_W-1:0]  p_vpn2;
    logic [ASID_W-1:0]  p_asid;
    logic               p_found;
    logic [IDX_W-1:0]   p_index;
    logic               w_we;
    logic [IDX_W-1:0]   w_index;
    logic [VPN2_W-1:0]  w_vpn2;
    logic [ASID_W-1:0]  w_asid;
    logic               w_g;
    logic [PFN_W-1:0]   w_pfn0;
    logic [CATTR_W-1:0] w_c0;
    logic               w_d0;
    logic               w_v0;
    logic [PFN_W-1:0]   w_pfn1;
    logic [CATTR_W-1:0] w_c1;
    logic               w_d1;
    logic               w_v1;
    logic [IDX_W-1:0]   r_index;
    logic [VPN2_W-1:0]  r_vpn2;
    logic [ASID_W-1:0]  r_asid;
    logic               r_g;
    logic [PFN_W-1:0]   r_pfn0;
    logic [CATTR_W-1:0] r_c0;
    logic               r_d0;
    logic               r_v0;
    logic [PFN_W-1:0]   r_pfn1;
    logic [CATTR_W-1:0] r_c1;
    logic               r_d1;
    logic               r_v1;

    cp0_regs #(.TLBNUM(TLBNUM)) i_regs (.*); // Port names match the nets above

    cp0_timer i_timer (.*);

    tlb #(.TLBNUM(TLBNUM)) i_tlb (.*);

endmodule

//--- logic/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int TLBNUM = tlb_pkg::TLBNUM_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    // Translation search
    input  logic [tlb_pkg::VPN2_W-1:0]  s_vpn2,
    input  logic                        s_odd_page,
    input  logic [tlb_pkg::ASID_W-1:0]  s_asid,
    output logic                        s_found,
    output logic [tlb_pkg::PFN_W-1:0]   s_pfn,
    output logic [tlb_pkg::CATTR_W-1:0] s_c,
    output logic                        s_d,
    output logic                        s_v,
    // Probe for tlbp
    input  logic [tlb_pkg::VPN2_W-1:0]  p_vpn2,
    input  logic [tlb_pkg::ASID_W-1:0]  p_asid,
    output logic                        p_found,
    output logic [$clog2(TLBNUM)-1:0]   p_index,
    // Write for tlbwi
    input  logic                        w_we,
    input  logic [$clog2(TLBNUM)-1:0]   w_index,
    input  logic [tlb_pkg::VPN2_W-1:0]  w_vpn2,
    input  logic [tlb_pkg::ASID_W-1:0]  w_asid,
    input  logic                        w_g,
    input  logic [tlb_pkg::PFN_W-1:0]   w_pfn0,
    input  logic [tlb_pkg::CATTR_W-1:0] w_c0,
    input  logic                        w_d0,
    input  logic                        w_v0,
    input  logic [tlb_pkg::PFN_W-1:0]   w_pfn1,
    input  logic [tlb_pkg::CATTR_W-1:0] w_c1,
    input  logic                        w_d1,
    input  logic                        w_v1,
    // Read for tlbr
    input  logic [$clog2(TLBNUM)-1:0]   r_index,
    output logic [tlb_pkg::VPN2_W-1:0]  r_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]  r_asid,
    output logic                        r_g,
    output logic [tlb_pkg::PFN_W-1:0]   r_pfn0,
    output logic [tlb_pkg::CATTR_W-1:0] r_c0,
    output logic                        r_d0,
    output logic                        r_v0,
    output logic [tlb_pkg::PFN_W-1:0]   r_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0] r_c1,
    output logic                        r_d1,
    output logic                        r_v1
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLBNUM);

    logic [VPN2_W-1:0]  e_vpn2 [TLBNUM];
    logic [ASID_W-1:0]  e_asid [TLBNUM];
    logic               e_g    [TLBNUM];
    logic [PFN_W-1:0]   e_pfn0 [TLBNUM];
    logic [CATTR_W-1:0] e_c0   [TLBNUM];
    logic               e_d0   [TLBNUM];
    logic               e_v0   [TLBNUM];
    logic [PFN_W-1:0]   e_pfn1 [TLBNUM];
    logic [CATTR_W-1:0] e_c1   [TLBNUM];
    logic               e_d1   [TLBNUM];
    logic               e_v1   [TLBNUM];
    logic [TLBNUM-1:0]  e_used; // Entry written since reset

    function automatic logic entry_match(input int i, input logic [VPN2_W-1:0] vpn2,
                                         input logic [ASID_W-1:0] asid);
        return e_used[i] && e_vpn2[i] == vpn2 && (e_g[i] || e_asid[i] == asid);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            e_used <= '0;
        end else if (w_we) begin
            e_used[w_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_we) begin
            e_vpn2[w_index] <= w_vpn2;
            e_asid[w_index] <= w_asid;
            e_g[w_index]    <= w_g;
            e_pfn0[w_index] <= w_pfn0;
            e_c0[w_index]   <= w_c0;
            e_d0[w_index]   <= w_d0;
            e_v0[w_index]   <= w_v0;
            e_pfn1[w_index] <= w_pfn1;
            e_c1[w_index]   <= w_c1;
            e_d1[w_index]   <= w_d1;
            e_v1[w_index]   <= w_v1;
        end
    end

    // Walk downward so the lowest matching entry wins on both ports
    always_comb begin
        s_found = 1'b0;
        s_pfn   = '0;
        s_c     = '0;
        s_d     = 1'b0;
        s_v     = 1'b0;
        p_found = 1'b0;
        p_index = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (entry_match(i, s_vpn2, s_asid)) begin
                s_found = 1'b1;
                s_pfn   = s_odd_page ? e_pfn1[i] : e_pfn0[i];
                s_c     = s_odd_page ? e_c1[i] : e_c0[i];
                s_d     = s_odd_page ? e_d1[i] : e_d0[i];
                s_v     = s_odd_page ? e_v1[i] : e_v0[i];
            end
            if (entry_match(i, p_vpn2, p_asid)) begin
                p_found = 1'b1;
                p_index = IDX_W'(i);
            end
        end
    end

    assign r_vpn2 = e_vpn2[r_index];
    assign r_asid = e_asid[r_index];
    assign r_g    = e_g[r_index];
    assign r_pfn0 = e_pfn0[r_index];
    assign r_c0   = e_c0[r_index];
    assign r_d0   = e_d0[r_index];
    assign r_v0   = e_v0[r_index];
    assign r_pfn1 = e_pfn1[r_index];
    assign r_c1   = e_c1[r_index];
    assign r_d1   = e_d1[r_index];
    assign r_v1   = e_v1[r_index];

endmodule

//--- logic/tlb_pkg.sv
package tlb_pkg;

    parameter int VPN2_W = 19; // VA[31:13], one even/odd page pair
    parameter int ASID_W = 8;
    parameter int PFN_W = 20; // 4 KB pages over a 32-bit PA
    parameter int CATTR_W = 3; // Cache attribute, stored only

    parameter int TLBNUM_DEFAULT = 16;

endpackage
